/* build.f */
+incdir+logic
logic/cc_pkg.sv
logic/offload_spill_reg.sv
logic/mul_pipe.sv
logic/div_serial.sv
logic/shared_muldiv.sv
logic/muldiv_cc.sv
dv/muldiv_cc_props.sv
dv/tb_muldiv_cc.sv

/* Bender.yml */
package:
  name: muldiv_cc

export_include_dirs:
  - logic

sources:
  - logic/cc_pkg.sv
  - logic/offload_spill_reg.sv
  - logic/mul_pipe.sv
  - logic/div_serial.sv
  - logic/shared_muldiv.sv
  - logic/muldiv_cc.sv
  - target: simulation
    files:
      - dv/muldiv_cc_props.sv
      - dv/tb_muldiv_cc.sv

/* dv/tb_muldiv_cc.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module tb_muldiv_cc;
  import cc_pkg::*;

  localparam int W           = `CC_DATA_W;
  localparam int NumIds      = 1 << `CC_ID_W;
  localparam int NumMul      = 60;
  localparam int NumDiv      = 40;
  localparam int NumSpec     = 8;
  localparam int NumMix      = 80;
  localparam int NumHold     = 80;
  localparam int NumReq      = NumMul + NumDiv + NumSpec + NumMix + NumHold;
  localparam int ResetCycles = 16;
  localparam int DrainCycles = NumIds * 60;
  localparam logic [31:0]  Seed   = 32'h656d2d36;
  localparam logic [W-1:0] MinNeg = {1'b1, {(W-1){1'b0}}};

  logic                clk_i, rst_i;
  logic                acc_qvalid_i, acc_qready_o, acc_pvalid_o, acc_pready_i;
  logic [`CC_ID_W-1:0] acc_qid_i, acc_pid_o;
  muldiv_op_e          acc_qop_i;
  logic [W-1:0]        acc_qarga_i, acc_qargb_i, acc_pdata_o;

  logic [31:0]  req_state, gap_state;
  logic [W-1:0] exp_data [NumIds];
  bit           busy [NumIds];
  int           outstanding, resp_count, hold_pct;
  int           data_errs, id_errs, flag_errs;

  muldiv_cc #(
    .RegisterOffloadReq  ( 1'b1 ),
    .RegisterOffloadResp ( 1'b1 )
  ) i_dut (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .acc_qvalid_i ( acc_qvalid_i ),
    .acc_qid_i    ( acc_qid_i    ),
    .acc_qop_i    ( acc_qop_i    ),
    .acc_qarga_i  ( acc_qarga_i  ),
    .acc_qargb_i  ( acc_qargb_i  ),
    .acc_qready_o ( acc_qready_o ),
    .acc_pvalid_o ( acc_pvalid_o ),
    .acc_pid_o    ( acc_pid_o    ),
    .acc_pdata_o  ( acc_pdata_o  ),
    .acc_pready_i ( acc_pready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------
  // Random numbers and model
  // ------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper halves only since the low LCG bits repeat too soon
  function automatic logic [31:0] next_rand();
    logic [31:0] hi;
    req_state = lcg_step(req_state);
    hi = req_state;
    req_state = lcg_step(req_state);
    return {hi[31:16], req_state[31:16]};
  endfunction

  // Corner values turn up often
  function automatic logic [W-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return '0;
      3'd1: return MinNeg;
      3'd2: return '1;
      3'd3: return {{(W-8){r[31]}}, r[15:8]};
      default: return next_rand();
    endcase
  endfunction

  function automatic logic [W-1:0] model_result(input muldiv_op_e op, input logic [W-1:0] a,
                                                input logic [W-1:0] b);
    logic signed [2*W-1:0] sa, sb, ua, ub, prod;
    logic [W-1:0]          quo, rem;
    logic                  sgn;
    sa = $signed(a);
    sb = $signed(b);
    ua = {{W{1'b0}}, a};
    ub = {{W{1'b0}}, b};
    if (!is_div(op)) begin
      case (op)
        MULH:    prod = sa * sb;
        MULHSU:  prod = sa * ub;
        default: prod = ua * ub;
      endcase
      return (op == MUL) ? prod[W-1:0] : prod[2*W-1:W];
    end
    sgn = (op == DIV) || (op == REM);
    if (b == '0) begin
      quo = '1;
      rem = a;
    end else if (sgn && a == MinNeg && b == '1) begin
      quo = a;
      rem = '0;
    end else if (sgn) begin
      quo = $signed(a) / $signed(b);
      rem = $signed(a) % $signed(b);
    end else begin
      quo = a / b;
      rem = a % b;
    end
    return (op == REM || op == REMU) ? rem : quo;
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic check_data(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("Fail %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input logic [`CC_ID_W-1:0] id, output bit ok);
    ok = busy[id];
    if (!ok) begin
      id_errs++;
      $display("Error at %0t: response carries ID %0d with no request outstanding", $time, id);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("Fail %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // ------------------------------
  // Core side driver
  // ------------------------------
  task automatic send_req(input muldiv_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
    logic [31:0]         r;
    logic [`CC_ID_W-1:0] id;
    while (outstanding == NumIds) @(negedge clk_i);
    r  = next_rand();
    id = r[`CC_ID_W-1:0];
    while (busy[id]) id = id + 1'b1;
    exp_data[id] = model_result(op, a, b);
    busy[id]     = 1'b1;
    outstanding++;
    acc_qvalid_i = 1'b1;
    acc_qid_i    = id;
    acc_qop_i    = op;
    acc_qarga_i  = a;
    acc_qargb_i  = b;
    do @(posedge clk_i); while (!acc_qready_o);
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
  endtask

  // Kind 0 sends multiplies and kind 1 divides; other kinds mix both
  task automatic run_stream(input int n, input int kind, input int gap_max);
    logic [31:0] r;
    muldiv_op_e  op;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      case (kind)
        0: op = muldiv_op_e'({1'b0, r[1:0]});
        1: op = muldiv_op_e'({1'b1, r[1:0]});
        default: op = muldiv_op_e'(r[2:0]);
      endcase
      send_req(op, pick_operand(), pick_operand());
      if (gap_max > 0) begin
        repeat (r[9:8] % (gap_max + 1)) @(negedge clk_i);
      end
    end
  endtask

  // Gives up once a full set of serial divides could have drained
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (outstanding != 0 && cycles < DrainCycles) begin
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // Random back-pressure on the response port
  always @(negedge clk_i) begin
    gap_state    = lcg_step(gap_state);
    acc_pready_i = rst_i || (gap_state[31:24] % 100 >= hold_pct);
  end

  always @(posedge clk_i) begin : collect_resp
    bit ok;
    if (!rst_i && acc_pvalid_o && acc_pready_i) begin
      check_id(acc_pid_o, ok);
      if (ok) begin
        check_data($sformatf("acc_pdata_o (ID %0d)", acc_pid_o), exp_data[acc_pid_o],
                   acc_pdata_o);
        busy[acc_pid_o] = 1'b0;
        outstanding--;
      end
      resp_count++;
    end
  end

  initial begin
    repeat (ResetCycles + NumReq * 60) @(posedge clk_i);
    $display("Error: watchdog expired with %0d requests outstanding", outstanding);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    req_state    = Seed;
    gap_state    = ~Seed;
    rst_i        = 1'b1;
    acc_qvalid_i = 1'b0;
    acc_qid_i    = '0;
    acc_qop_i    = MUL;
    acc_qarga_i  = '0;
    acc_qargb_i  = '0;
    acc_pready_i = 1'b1;
    outstanding  = 0;
    resp_count   = 0;
    hold_pct     = 0;
    data_errs    = 0;
    id_errs      = 0;
    flag_errs    = 0;
    foreach (busy[k]) busy[k] = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_i = 1'b0;

    // Quiet port until the first request
    repeat (4) begin
      @(posedge clk_i);
      check_bit("acc_pvalid_o", 1'b0, acc_pvalid_o);
      check_bit("acc_qready_o", 1'b1, acc_qready_o);
    end
    @(negedge clk_i);

    run_stream(NumMul, 0, 0);
    wait_idle();
    run_stream(NumDiv, 1, 2);
    wait_idle();
    // Divide by zero and then most negative over minus one
    for (int k = 4; k < 8; k++) begin
      r = next_rand();
      send_req(muldiv_op_e'(k[2:0]), r, '0);
      send_req(muldiv_op_e'(k[2:0]), MinNeg, '1);
    end
    wait_idle();
    run_stream(NumMix, 2, 1);
    hold_pct = 50;
    run_stream(NumHold, 2, 1);
    hold_pct = 0;
    wait_idle();

    @(posedge clk_i);
    check_bit("acc_qready_o", 1'b1, acc_qready_o);
    check_bit("acc_pvalid_o", 1'b0, acc_pvalid_o);
    foreach (busy[k]) begin
      if (busy[k]) begin
        flag_errs++;
        $display("Error: ID %0d is still outstanding at the end", k);
      end
    end
    if (resp_count != NumReq) begin
      flag_errs++;
      $display("Error: %0d responses seen for %0d requests", resp_count, NumReq);
    end
    $display("Checks done: %0d data errors, %0d ID errors, %0d other errors",
             data_errs, id_errs, flag_errs);
    if (data_errs + id_errs + flag_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/muldiv_cc_props.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module muldiv_cc_props (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  acc_pvalid_o,
  input logic                  acc_pready_i,
  input logic [`CC_ID_W-1:0]   acc_pid_o,
  input logic [`CC_DATA_W-1:0] acc_pdata_o
);

  // Response waits for the core
  a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_pvalid_o && !acc_pready_i |=>
      acc_pvalid_o && $stable(acc_pid_o) && $stable(acc_pdata_o))
    else $error("offload response dropped or changed before it was taken");

  a_quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !acc_pvalid_o)
    else $error("offload response valid during reset");

  a_id_known: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_pvalid_o |-> !$isunknown(acc_pid_o))
    else $error("offload response ID has unknown bits");

endmodule

bind muldiv_cc muldiv_cc_props i_props (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .acc_pvalid_o ( acc_pvalid_o ),
  .acc_pready_i ( acc_pready_i ),
  .acc_pid_o    ( acc_pid_o    ),
  .acc_pdata_o  ( acc_pdata_o  )
);

`default_nettype wire

/* logic/muldiv_cc.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module muldiv_cc #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Offload request from the core side
  input  logic                  acc_qvalid_i,
  input  logic [`CC_ID_W-1:0]   acc_qid_i,
  input  cc_pkg::muldiv_op_e    acc_qop_i,
  input  logic [`CC_DATA_W-1:0] acc_qarga_i,
  input  logic [`CC_DATA_W-1:0] acc_qargb_i,
  output logic                  acc_qready_o,
  // Offload response to the core side
  output logic                  acc_pvalid_o,
  output logic [`CC_ID_W-1:0]   acc_pid_o,
  output logic [`CC_DATA_W-1:0] acc_pdata_o,
  input  logic                  acc_pready_i
);
  import cc_pkg::*;

  localparam int unsigned OpW   = $bits(muldiv_op_e);
  localparam int unsigned ReqW  = `CC_ID_W + OpW + 2 * `CC_DATA_W;
  localparam int unsigned RespW = `CC_ID_W + `CC_DATA_W;

  logic [ReqW-1:0]       req_data;
  logic                  req_valid, req_ready;
  logic [`CC_ID_W-1:0]   req_id;
  logic [OpW-1:0]        req_op;
  logic [`CC_DATA_W-1:0] req_arga, req_argb;

  logic                  resp_valid, resp_ready;
  logic [`CC_ID_W-1:0]   resp_id;
  logic [`CC_DATA_W-1:0] resp_data;
  logic [RespW-1:0]      resp_q;

  // Cut the offload request path
  offload_spill_reg #(
    .Width  ( ReqW                ),
    .Bypass ( !RegisterOffloadReq )
  ) i_spill_acc_req (
    .clk_i   ( clk_i                                              ),
    .rst_i   ( rst_i                                              ),
    .valid_i ( acc_qvalid_i                                       ),
    .data_i  ( {acc_qid_i, acc_qop_i, acc_qarga_i, acc_qargb_i}   ),
    .ready_o ( acc_qready_o                                       ),
    .valid_o ( req_valid                                          ),
    .data_o  ( req_data                                           ),
    .ready_i ( req_ready                                          )
  );

  assign {req_id, req_op, req_arga, req_argb} = req_data;

  shared_muldiv i_shared_muldiv (
    .clk_i        ( clk_i               ),
    .rst_i        ( rst_i               ),
    .acc_qvalid_i ( req_valid           ),
    .acc_qid_i    ( req_id              ),
    .acc_qop_i    ( muldiv_op_e'(req_op) ),
    .acc_qarga_i  ( req_arga            ),
    .acc_qargb_i  ( req_argb            ),
    .acc_qready_o ( req_ready           ),
    .acc_pvalid_o ( resp_valid          ),
    .acc_pid_o    ( resp_id             ),
    .acc_pdata_o  ( resp_data           ),
    .acc_pready_i ( resp_ready          )
  );

  // Cut the offload response path
  offload_spill_reg #(
    .Width  ( RespW                ),
    .Bypass ( !RegisterOffloadResp )
  ) i_spill_acc_resp (
    .clk_i   ( clk_i                ),
    .rst_i   ( rst_i                ),
    .valid_i ( resp_valid           ),
    .data_i  ( {resp_id, resp_data} ),
    .ready_o ( resp_ready           ),
    .valid_o ( acc_pvalid_o         ),
    .data_o  ( resp_q               ),
    .ready_i ( acc_pready_i         )
  );

  assign {acc_pid_o, acc_pdata_o} = resp_q;

endmodule

`default_nettype wire

/* logic/shared_muldiv.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module shared_muldiv (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Offload request
  input  logic                  acc_qvalid_i,
  input  logic [`CC_ID_W-1:0]   acc_qid_i,
  input  cc_pkg::muldiv_op_e    acc_qop_i,
  input  logic [`CC_DATA_W-1:0] acc_qarga_i,
  input  logic [`CC_DATA_W-1:0] acc_qargb_i,
  output logic                  acc_qready_o,
  // Offload response
  output logic                  acc_pvalid_o,
  output logic [`CC_ID_W-1:0]   acc_pid_o,
  output logic [`CC_DATA_W-1:0] acc_pdata_o,
  input  logic                  acc_pready_i
);
  import cc_pkg::*;

  logic                  sel_div;
  logic                  mul_qvalid, mul_qready;
  logic                  div_qvalid, div_qready;
  logic                  mul_pvalid, mul_pready;
  logic                  div_pvalid, div_pready;
  logic [`CC_ID_W-1:0]   mul_pid, div_pid;
  logic [`CC_DATA_W-1:0] mul_pdata, div_pdata;

  // ------------------------------
  // Request steering
  // ------------------------------
  assign sel_div      = is_div(acc_qop_i);
  assign mul_qvalid   = acc_qvalid_i && is_mul(acc_qop_i);
  assign div_qvalid   = acc_qvalid_i && sel_div;
  assign acc_qready_o = sel_div ? div_qready : mul_qready;

  mul_pipe i_mul_pipe (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .valid_i  ( mul_qvalid  ),
    .id_i     ( acc_qid_i   ),
    .op_i     ( acc_qop_i   ),
    .a_i      ( acc_qarga_i ),
    .b_i      ( acc_qargb_i ),
    .ready_o  ( mul_qready  ),
    .valid_o  ( mul_pvalid  ),
    .id_o     ( mul_pid     ),
    .result_o ( mul_pdata   ),
    .ready_i  ( mul_pready  )
  );

  div_serial i_div_serial (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .valid_i  ( div_qvalid  ),
    .id_i     ( acc_qid_i   ),
    .op_i     ( acc_qop_i   ),
    .a_i      ( acc_qarga_i ),
    .b_i      ( acc_qargb_i ),
    .ready_o  ( div_qready  ),
    .valid_o  ( div_pvalid  ),
    .id_o     ( div_pid     ),
    .result_o ( div_pdata   ),
    .ready_i  ( div_pready  )
  );

  // ------------------------------
  // Response arbitration
  // ------------------------------

  // Multiplier has fixed priority, it cannot hold results for long
  assign acc_pvalid_o = mul_pvalid || div_pvalid;
  assign acc_pid_o    = mul_pvalid ? mul_pid : div_pid;
  assign acc_pdata_o  = mul_pvalid ? mul_pdata : div_pdata;

  // Only the winner sees the port ready
  assign mul_pready = acc_pready_i;
  assign div_pready = acc_pready_i && !mul_pvalid;

endmodule

`default_nettype wire

/* logic/div_serial.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module div_serial (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic [`CC_ID_W-1:0]   id_i,
  input  cc_pkg::muldiv_op_e    op_i,
  input  logic [`CC_DATA_W-1:0] a_i,
  input  logic [`CC_DATA_W-1:0] b_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output logic [`CC_ID_W-1:0]   id_o,
  output logic [`CC_DATA_W-1:0] result_o,
  input  logic                  ready_i
);
  import cc_pkg::*;

  localparam int unsigned W    = `CC_DATA_W;
  localparam int unsigned CntW = $clog2(W) + 1;
  // Steps 0 to W-1 shift, step W fixes the signs
  localparam logic [CntW-1:0] LastStep = CntW'(W);
  localparam logic [W-1:0]    MinNeg   = {1'b1, {(W-1){1'b0}}};

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StRun  = 2'd1;
  localparam logic [1:0] StDone = 2'd2;

  logic [1:0]          state_q;
  logic [CntW-1:0]     cnt_q;
  logic [W-1:0]        quo_q, rem_q, dvsr_q, res_q;
  logic [`CC_ID_W-1:0] id_q;
  logic                neg_quo_q, neg_rem_q, want_rem_q;

  logic         op_signed, op_rem, neg_a, neg_b;
  logic         div_zero, overflow;
  logic [W-1:0] abs_a, abs_b;
  logic [W:0]   shifted;
  logic [W+1:0] trial;
  logic         fits;

  // ------------------------------
  // Request decode
  // ------------------------------
  assign op_signed = (op_i == DIV) || (op_i == REM);
  assign op_rem    = (op_i == REM) || (op_i == REMU);
  assign neg_a     = op_signed & a_i[W-1];
  assign neg_b     = op_signed & b_i[W-1];
  assign abs_a     = neg_a ? -a_i : a_i;
  assign abs_b     = neg_b ? -b_i : b_i;
  assign div_zero  = (b_i == '0);
  assign overflow  = op_signed && (a_i == MinNeg) && (b_i == '1);

  // Restoring step
  assign shifted = {rem_q, quo_q[W-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvsr_q};
  assign fits    = !trial[W+1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (valid_i) begin
            cnt_q   <= '0;
            state_q <= (div_zero || overflow) ? StDone : StRun;
          end
        end
        StRun: begin
          if (cnt_q == LastStep) begin
            state_q <= StDone;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        StDone: begin
          if (ready_i) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && valid_i) begin
      id_q       <= id_i;
      want_rem_q <= op_rem;
      neg_quo_q  <= neg_a ^ neg_b;
      neg_rem_q  <= neg_a;
      quo_q      <= abs_a;
      rem_q      <= '0;
      dvsr_q     <= abs_b;
      // RISC-V special results skip the loop
      if (div_zero) begin
        res_q <= op_rem ? a_i : '1;
      end else if (overflow) begin
        res_q <= op_rem ? '0 : a_i;
      end
    end else if (state_q == StRun) begin
      if (cnt_q == LastStep) begin
        res_q <= want_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                            : (neg_quo_q ? -quo_q : quo_q);
      end else begin
        rem_q <= fits ? trial[W-1:0] : shifted[W-1:0];
        quo_q <= {quo_q[W-2:0], fits};
      end
    end
  end

  assign ready_o  = (state_q == StIdle);
  assign valid_o  = (state_q == StDone);
  assign id_o     = id_q;
  assign result_o = res_q;

endmodule

`default_nettype wire

/* logic/mul_pipe.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"
`default_nettype none

module mul_pipe (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic [`CC_ID_W-1:0]   id_i,
  input  cc_pkg::muldiv_op_e    op_i,
  input  logic [`CC_DATA_W-1:0] a_i,
  input  logic [`CC_DATA_W-1:0] b_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output logic [`CC_ID_W-1:0]   id_o,
  output logic [`CC_DATA_W-1:0] result_o,
  input  logic                  ready_i
);
  import cc_pkg::*;

  localparam int unsigned Stages = `CC_MUL_STAGES;
  localparam int unsigned DataW  = `CC_DATA_W;
  localparam int unsigned ExtW   = DataW + 1;

  logic [Stages-1:0]        vld_q;
  logic [`CC_ID_W-1:0]      id_q [Stages];
  muldiv_op_e               op_q [Stages-1];
  logic                     advance;
  logic                     a_signed, b_signed;
  logic signed [ExtW-1:0]   opa_d, opb_d, opa_q, opb_q;
  logic signed [2*ExtW-1:0] prod_full;
  logic [2*DataW-1:0]       prod_q;
  logic [DataW-1:0]         res_q;

  // Whole pipe moves together, so one enable
  assign advance = !vld_q[Stages-1] || ready_i;
  assign ready_o = advance;

  // Stage one operand extension
  assign a_signed = (op_i == MULH) || (op_i == MULHSU);
  assign b_signed = (op_i == MULH);
  assign opa_d    = {a_signed & a_i[DataW-1], a_i};
  assign opb_d    = {b_signed & b_i[DataW-1], b_i};

  // Stage two product, 33x33 signed covers all sign mixes
  assign prod_full = opa_q * opb_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[Stages-2:0], valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      id_q[0] <= id_i;
      for (int i = 1; i < Stages; i++) begin
        id_q[i] <= id_q[i-1];
      end
      op_q[0] <= op_i;
      for (int i = 1; i < Stages - 1; i++) begin
        op_q[i] <= op_q[i-1];
      end
      opa_q  <= opa_d;
      opb_q  <= opb_d;
      prod_q <= prod_full[2*DataW-1:0];
      // Stage three word select
      res_q  <= (op_q[Stages-2] == MUL) ? prod_q[DataW-1:0] : prod_q[2*DataW-1:DataW];
    end
  end

  assign valid_o  = vld_q[Stages-1];
  assign id_o     = id_q[Stages-1];
  assign result_o = res_q;

endmodule

`default_nettype wire

/* logic/offload_spill_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module offload_spill_reg #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic [Width-1:0] data_i,
  output logic             ready_o,
  output logic             valid_o,
  output logic [Width-1:0] data_o,
  input  logic             ready_i
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign data_o  = data_i;
    assign ready_o = ready_i;
  end else begin : gen_spill
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // Slot A takes every new item
    assign a_fill  = valid_i && ready_o;
    // A empties whenever B is free, either downstream or into B
    assign a_drain = a_full_q && !b_full_q;
    // Spill into B only if downstream does not take A
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B holds the older item when both are full
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;
  end

endmodule

`default_nettype wire

/* logic/cc_pkg.sv */
`default_nettype none

package cc_pkg;

  // ------------------------------
  // Offload operations
  // ------------------------------

  // Encoded in RISC-V M funct3 order
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  // Quotient and remainder go to the serial divider
  function automatic logic is_div(input muldiv_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  // Product words go to the pipelined multiplier
  function automatic logic is_mul(input muldiv_op_e op);
    return op inside {MUL, MULH, MULHSU, MULHU};
  endfunction

endpackage

`default_nettype wire

/* logic/cc_defines.svh */
`ifndef CC_DEFINES_SVH
`define CC_DEFINES_SVH

// Operand and result width
`define CC_DATA_W 32

// Response tag width with one tag per outstanding offload
`define CC_ID_W 5

// Register stages in the multiplier
`define CC_MUL_STAGES 3

`endif
